/* verilog/jade_pkg.sv */
`default_nettype none

package jade_pkg;

    // machine sizes
    localparam int WORD_SIZE    = 32;
    localparam int NUM_FLAGS    = 2;
    localparam int ROB_ENTRY    = 16;
    localparam int NUM_PHYS_REG = 64;
    localparam int NUM_FU       = 4;

    // derived index widths
    localparam int SHAMT_W  = $clog2(WORD_SIZE);
    localparam int FU_IDX_W = $clog2(NUM_FU);

    // flag bit positions
    localparam int FLAG_NEG  = 1;
    localparam int FLAG_ZERO = 0;

    typedef logic [WORD_SIZE-1:0]            word_t;
    typedef logic [NUM_FLAGS-1:0]            flags_t;
    typedef logic [$clog2(ROB_ENTRY)-1:0]    rob_tag_t;
    typedef logic [$clog2(NUM_PHYS_REG)-1:0] preg_t;
    typedef logic [2:0]                      logic_op_t;
    typedef logic [NUM_FU-1:0]               fu_sel_t;
    typedef logic [FU_IDX_W-1:0]             fu_idx_t;
    typedef logic [SHAMT_W-1:0]              shamt_t;

    // opcodes, all eight are legal
    localparam logic_op_t OP_AND  = 3'd0;
    localparam logic_op_t OP_XOR  = 3'd1;
    localparam logic_op_t OP_OR   = 3'd2;
    localparam logic_op_t OP_NEG  = 3'd3;
    localparam logic_op_t OP_LSLS = 3'd4;
    localparam logic_op_t OP_LSRS = 3'd5;
    localparam logic_op_t OP_ASRS = 3'd6;
    localparam logic_op_t OP_RORS = 3'd7;

    // issued micro-op, 77 bits
    typedef struct packed {
        logic_op_t opcode;
        word_t     operand1;
        word_t     operand2;
        rob_tag_t  rob_dest;
        preg_t     reg_dest;
    } issue_req_t;

    // common data bus payload, 40 bits
    typedef struct packed {
        preg_t  dest;
        flags_t flags;
        word_t  result;
    } cdb_t;

    // writeback record toward the ROB, 44 bits
    typedef struct packed {
        rob_tag_t rob_dest;
        cdb_t     cdb;
    } rob_wb_t;

endpackage

`default_nettype wire

/* verilog/issue_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_dispatch
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 issue_valid_i,
    input  jade_pkg::issue_req_t issue_i,
    output logic                 issue_ready_o,
    input  jade_pkg::fu_sel_t    fu_free_i,
    output jade_pkg::fu_sel_t    fu_issue_v_o,
    output jade_pkg::issue_req_t fu_req_o
);

    // rotating start point for the search
    jade_pkg::fu_idx_t start_ptr_r;
    jade_pkg::fu_idx_t pick;
    logic              found;
    logic              accept;

    // first free unit at or after the start pointer
    always_comb
    begin : find_free
        jade_pkg::fu_idx_t cand;
        found = 1'b0;
        pick  = start_ptr_r;
        cand  = start_ptr_r;
        for (int i = 0; i < jade_pkg::NUM_FU; i++)
        begin
            // index wraps through the width of fu_idx_t
            cand = start_ptr_r + jade_pkg::fu_idx_t'(i);
            if (!found && fu_free_i[cand])
            begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    assign issue_ready_o = |fu_free_i;
    assign accept        = issue_valid_i && issue_ready_o;

    // one-hot strobe into the chosen unit
    always_comb
    begin
        fu_issue_v_o = '0;
        if (issue_valid_i && found)
        begin
            fu_issue_v_o[pick] = 1'b1;
        end
    end

    // payload is shared, only the strobe selects the taker
    assign fu_req_o = issue_i;

    // move the start point past the unit that took the op
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            start_ptr_r <= '0;
        end
        else if (accept)
        begin
            start_ptr_r <= pick + jade_pkg::fu_idx_t'(1);
        end
    end

endmodule

`default_nettype wire

/* verilog/fu_logic.sv */
`timescale 1ns/100ps
`default_nettype none

module fu_logic
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 exe_v_i,
    input  jade_pkg::issue_req_t req_i,
    input  logic                 grant_i,
    output logic                 free_o,
    output logic                 slot_valid_o,
    output jade_pkg::rob_wb_t    slot_o
);

    jade_pkg::word_t   op1;
    jade_pkg::word_t   op2;
    jade_pkg::word_t   result;
    jade_pkg::flags_t  flags;
    jade_pkg::shamt_t  rot_amt;
    jade_pkg::rob_wb_t slot_n;
    jade_pkg::rob_wb_t slot_r;
    logic              slot_valid_r;

    assign op1     = req_i.operand1;
    assign op2     = req_i.operand2;
    assign rot_amt = op2[jade_pkg::SHAMT_W-1:0];

    // shifts take the whole operand2, so large amounts flush out
    always_comb
    begin
        unique case (req_i.opcode)
            jade_pkg::OP_AND:  result = op1 & op2;
            jade_pkg::OP_XOR:  result = op1 ^ op2;
            jade_pkg::OP_OR:   result = op1 | op2;
            jade_pkg::OP_NEG:  result = ~op1;
            jade_pkg::OP_LSLS: result = op1 << op2;
            jade_pkg::OP_LSRS: result = op1 >> op2;
            // sign fill for amounts of 32 and up
            jade_pkg::OP_ASRS: result = $signed(op1) >>> op2;
            // a zero amount makes the left part vanish, leaving op1
            jade_pkg::OP_RORS: result = (op1 >> rot_amt)
                                      | (op1 << (jade_pkg::WORD_SIZE - int'(rot_amt)));
        endcase
    end

    // negative and zero flags
    always_comb
    begin
        flags                     = '0;
        flags[jade_pkg::FLAG_NEG] = result[jade_pkg::WORD_SIZE-1];
        flags[jade_pkg::FLAG_ZERO] = (result == '0);
    end

    always_comb
    begin
        slot_n.rob_dest     = req_i.rob_dest;
        slot_n.cdb.dest     = req_i.reg_dest;
        slot_n.cdb.flags    = flags;
        slot_n.cdb.result   = result;
    end

    // a new op may enter in the same cycle the old one is granted
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            slot_valid_r <= 1'b0;
        end
        else if (exe_v_i)
        begin
            slot_valid_r <= 1'b1;
        end
        else if (grant_i)
        begin
            slot_valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (exe_v_i)
        begin
            slot_r <= slot_n;
        end
    end

    assign free_o       = !slot_valid_r || grant_i;
    assign slot_valid_o = slot_valid_r;
    assign slot_o       = slot_r;

endmodule

`default_nettype wire

/* verilog/cdb_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  jade_pkg::fu_sel_t slot_valid_i,
    input  jade_pkg::rob_wb_t slot_i [jade_pkg::NUM_FU],
    output jade_pkg::fu_sel_t grant_o,
    output logic              cdb_valid_o,
    output jade_pkg::rob_wb_t cdb_o,
    input  logic              cdb_ready_i
);

    jade_pkg::fu_idx_t rr_ptr_r;
    jade_pkg::fu_idx_t pick;
    logic              found;
    logic              can_load;
    logic              cdb_valid_r;
    jade_pkg::rob_wb_t cdb_r;

    // output register is empty or leaving this cycle
    assign can_load = !cdb_valid_r || cdb_ready_i;

    // round-robin search from the pointer
    always_comb
    begin : rr_search
        jade_pkg::fu_idx_t cand;
        found = 1'b0;
        pick  = rr_ptr_r;
        cand  = rr_ptr_r;
        for (int i = 0; i < jade_pkg::NUM_FU; i++)
        begin
            cand = rr_ptr_r + jade_pkg::fu_idx_t'(i);
            if (!found && slot_valid_i[cand])
            begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    always_comb
    begin
        grant_o = '0;
        if (can_load && found)
        begin
            grant_o[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            cdb_valid_r <= 1'b0;
            rr_ptr_r    <= '0;
        end
        else if (can_load)
        begin
            cdb_valid_r <= found;
            if (found)
            begin
                rr_ptr_r <= pick + jade_pkg::fu_idx_t'(1);
            end
        end
    end

    // record holds while the ROB stalls
    always_ff @(posedge clk_i)
    begin
        if (can_load && found)
        begin
            cdb_r <= slot_i[pick];
        end
    end

    assign cdb_valid_o = cdb_valid_r;
    assign cdb_o       = cdb_r;

endmodule

`default_nettype wire

/* verilog/logic_cluster.sv */
`timescale 1ns/100ps
`default_nettype none

module logic_cluster
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 issue_valid_i,
    input  jade_pkg::issue_req_t issue_i,
    output logic                 issue_ready_o,
    output logic                 cdb_valid_o,
    output jade_pkg::rob_wb_t    cdb_o,
    input  logic                 cdb_ready_i
);

    jade_pkg::fu_sel_t    fu_free;
    jade_pkg::fu_sel_t    fu_issue_v;
    jade_pkg::issue_req_t fu_req;
    jade_pkg::fu_sel_t    slot_valid;
    jade_pkg::rob_wb_t    slot [jade_pkg::NUM_FU];
    jade_pkg::fu_sel_t    grant;

    issue_dispatch u_dispatch
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .fu_free_i     (fu_free),
        .fu_issue_v_o  (fu_issue_v),
        .fu_req_o      (fu_req)
    );

    // identical logic units, each with its own result slot
    for (genvar g = 0; g < jade_pkg::NUM_FU; g++)
    begin : g_fu
        fu_logic u_fu
        (
            .clk_i        (clk_i),
            .reset_i      (reset_i),
            .exe_v_i      (fu_issue_v[g]),
            .req_i        (fu_req),
            .grant_i      (grant[g]),
            .free_o       (fu_free[g]),
            .slot_valid_o (slot_valid[g]),
            .slot_o       (slot[g])
        );
    end

    cdb_arbiter u_arbiter
    (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .slot_valid_i (slot_valid),
        .slot_i       (slot),
        .grant_o      (grant),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_o        (cdb_o),
        .cdb_ready_i  (cdb_ready_i)
    );

endmodule

`default_nettype wire

/* test/logic_cluster_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module logic_cluster_checker
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  jade_pkg::fu_sel_t slot_valid_i,
    input  jade_pkg::fu_sel_t grant_o,
    input  logic              cdb_valid_o,
    input  jade_pkg::rob_wb_t cdb_o,
    input  logic              cdb_ready_i
);

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(grant_o))
        else $error("grant is not one-hot or zero");

    // a grant must point at a full slot
    a_grant_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        (grant_o & ~slot_valid_i) == '0)
        else $error("grant given to an empty slot");

    a_cdb_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        cdb_valid_o && !cdb_ready_i |=> cdb_valid_o && $stable(cdb_o))
        else $error("cdb record changed while stalled");

    a_reset_idle: assert property (@(posedge clk_i) reset_i |=> !cdb_valid_o)
        else $error("cdb valid high right after reset");

endmodule

bind cdb_arbiter logic_cluster_checker u_checker
(
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .slot_valid_i (slot_valid_i),
    .grant_o      (grant_o),
    .cdb_valid_o  (cdb_valid_o),
    .cdb_o        (cdb_o),
    .cdb_ready_i  (cdb_ready_i)
);

`default_nettype wire

/* test/logic_cluster_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module logic_cluster_tb;

    localparam int NUM_OPS   = 2000;
    localparam int BURST_OPS = 100;
    localparam int STALL_LEN = 40;

    logic                 clk_i = 1'b0;
    logic                 reset_i;
    logic                 issue_valid_i;
    jade_pkg::issue_req_t issue_i;
    logic                 issue_ready_o;
    logic                 cdb_valid_o;
    jade_pkg::rob_wb_t    cdb_o;
    logic                 cdb_ready_i;

    integer             seed = 32'h5eb82291;
    jade_pkg::rob_tag_t free_tags [$];
    jade_pkg::cdb_t     expected [jade_pkg::ROB_ENTRY];
    logic               in_flight [jade_pkg::ROB_ENTRY];
    int                 issued;
    int                 accepted;
    int                 returned;
    int                 stall_left;
    int                 burst_cycle;
    int                 window_xfers;
    logic               pending;
    logic               stall_done;
    logic               saw_ready_low;
    logic               saw_recover;
    string              end_problem;

    logic_cluster uut
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_o         (cdb_o),
        .cdb_ready_i   (cdb_ready_i)
    );

    always #5 clk_i = ~clk_i;

    // reference model, shifts done one bit at a time
    function automatic jade_pkg::cdb_t model_result(jade_pkg::issue_req_t req);
        jade_pkg::word_t a;
        jade_pkg::word_t r;
        int              n;
        int              rot;
        a   = req.operand1;
        r   = a;
        n   = (req.operand2 >= 32) ? 32 : int'(req.operand2);
        rot = int'(req.operand2[4:0]);
        case (req.opcode)
            jade_pkg::OP_AND:  r = a & req.operand2;
            jade_pkg::OP_XOR:  r = a ^ req.operand2;
            jade_pkg::OP_OR:   r = a | req.operand2;
            jade_pkg::OP_NEG:  r = ~a;
            jade_pkg::OP_LSLS: for (int i = 0; i < n; i++) r = {r[30:0], 1'b0};
            jade_pkg::OP_LSRS: for (int i = 0; i < n; i++) r = {1'b0, r[31:1]};
            jade_pkg::OP_ASRS: for (int i = 0; i < n; i++) r = {r[31], r[31:1]};
            jade_pkg::OP_RORS: for (int i = 0; i < rot; i++) r = {r[0], r[31:1]};
        endcase
        return '{dest: req.reg_dest, flags: {r[31], (r == '0)}, result: r};
    endfunction

    task stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task drive_inputs();
        logic [31:0] rnd;
        logic        go;
        int          sel;
        if (!stall_done && issued >= 800)
        begin
            stall_left = STALL_LEN;
            stall_done = 1'b1;
        end
        go = (issued >= NUM_OPS - BURST_OPS) || (({$random(seed)} % 4) != 0);
        if (!pending && go && issued < NUM_OPS && free_tags.size() > 0)
        begin
            rnd              = $random(seed);
            issue_i.opcode   = rnd[2:0];
            issue_i.reg_dest = rnd[13:8];
            issue_i.operand1 = $random(seed);
            sel              = {$random(seed)} % 8;
            // mostly small shift amounts, some of 32 and up
            if (sel < 5)
                issue_i.operand2 = {$random(seed)} % 32;
            else if (sel == 5)
                issue_i.operand2 = 32 + {$random(seed)} % 32;
            else
                issue_i.operand2 = $random(seed);
            issue_i.rob_dest = free_tags.pop_front();
            pending          = 1'b1;
            issued++;
        end
        issue_valid_i = pending;
        if (stall_left > 0)
        begin
            cdb_ready_i = 1'b0;
            stall_left--;
        end
        else if (issued >= NUM_OPS - BURST_OPS)
            cdb_ready_i = 1'b1;
        else
            cdb_ready_i = ({$random(seed)} % 10) < 6;
    endtask

    task observe_edge();
        jade_pkg::rob_tag_t tag;
        if (cdb_valid_o && cdb_ready_i)
        begin
            tag = cdb_o.rob_dest;
            if (!in_flight[tag])
            begin
                $display("result for tag %0d arrived with no micro-op outstanding", tag);
                stop_with_failure();
            end
            check_value("cdb_o.cdb.dest", 64'(cdb_o.cdb.dest), 64'(expected[tag].dest));
            check_value("cdb_o.cdb.flags", 64'(cdb_o.cdb.flags), 64'(expected[tag].flags));
            check_value("cdb_o.cdb.result", 64'(cdb_o.cdb.result), 64'(expected[tag].result));
            in_flight[tag] = 1'b0;
            free_tags.push_back(tag);
            returned++;
            if (burst_cycle >= 10 && burst_cycle < 60)
                window_xfers++;
        end
        if (issue_valid_i && issue_ready_o)
        begin
            expected[issue_i.rob_dest]  = model_result(issue_i);
            in_flight[issue_i.rob_dest] = 1'b1;
            pending                     = 1'b0;
            accepted++;
        end
        if (stall_left > 0 && !issue_ready_o)
            saw_ready_low = 1'b1;
        if (saw_ready_low && issue_ready_o)
            saw_recover = 1'b1;
        if (issued >= NUM_OPS - BURST_OPS)
            burst_cycle++;
    endtask

    initial
    begin
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        cdb_ready_i   = 1'b0;
        pending       = 1'b0;
        stall_done    = 1'b0;
        saw_ready_low = 1'b0;
        saw_recover   = 1'b0;
        issued        = 0;
        accepted      = 0;
        returned      = 0;
        stall_left    = 0;
        burst_cycle   = 0;
        window_xfers  = 0;
        end_problem   = "";
        for (int t = 0; t < jade_pkg::ROB_ENTRY; t++)
        begin
            free_tags.push_back(jade_pkg::rob_tag_t'(t));
            in_flight[t] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        #1 reset_i = 1'b0;
        @(posedge clk_i);
        // idle state before the first issue
        check_value("cdb_valid_o", 64'(cdb_valid_o), 64'd0);
        check_value("issue_ready_o", 64'(issue_ready_o), 64'd1);
        while (!(issued == NUM_OPS && !pending && returned == accepted))
        begin
            #1;
            drive_inputs();
            @(posedge clk_i);
            observe_edge();
        end
        if (free_tags.size() != jade_pkg::ROB_ENTRY)
            end_problem = "tag pool is not full at the end of the run";
        else if (!saw_ready_low || !saw_recover)
            end_problem = "issue_ready_o did not drop and recover around the long stall";
        else if (window_xfers + 2 < 50)
            end_problem = $sformatf("only %0d transfers in the 50-cycle window", window_xfers);
        if (end_problem.len() > 0)
        begin
            $display("%s", end_problem);
            stop_with_failure();
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

    // watchdog
    initial
    begin
        repeat (NUM_OPS * 12) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d cycles", NUM_OPS * 12);
        stop_with_failure();
    end

endmodule

`default_nettype wire

/* files.f */
verilog/jade_pkg.sv
verilog/issue_dispatch.sv
verilog/fu_logic.sv
verilog/cdb_arbiter.sv
verilog/logic_cluster.sv
test/logic_cluster_checker.sv
test/logic_cluster_tb.sv

/* Makefile */
# build and run the cluster testbench with Verilator

TOP := logic_cluster_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
